/* Makefile */
# Verilator build and run of the fetch unit testbench
TOP = tb_fetch

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f project.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

/* fetch_bus_pkg.sv */
// Data carried between the fetch blocks
// cache line, queue entry, predecoded slot and return stack operation
`default_nettype none

`include "fetch_cfg.svh"

package fetch_bus_pkg;

   import fetch_isa_pkg::*;

   typedef logic [`FETCH_LINE_BYTES*8-1:0] line_t;       // one whole cache line
   typedef logic [$clog2(`FETCH_Q_DEPTH):0] count_t;     // 0..queue depth

   typedef struct packed {
      logic [INSTR_W-1:0]     instruction;
      logic [`FETCH_PC_W-1:0] pc;
      logic [`FETCH_PC_W-1:0] predicted_addr;
   } queue_entry_t;

   // fields pulled out of one instruction word during the line walk
   typedef struct packed {
      logic [INSTR_W-1:0]     instr;
      logic                   is32;                      // low bits say 32-bit encoding
      branch_kind_e           kind;
      logic [`FETCH_PC_W-1:0] i_imm;
      logic [`FETCH_PC_W-1:0] b_imm;
      logic [`FETCH_PC_W-1:0] j_imm;
      logic [REG_W-1:0]       rd;
      logic [REG_W-1:0]       rs1;
   } slot_t;

   typedef struct packed {
      logic                   push;
      logic                   pop;                       // applied before push
      logic [`FETCH_PC_W-1:0] push_addr;
   } ras_op_t;

endpackage

`default_nettype wire

/* fetch_cfg.svh */
// Fetch unit configuration
// sizes of the program counter, cache line, instruction queue and return stack
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

`define FETCH_PC_W        32        // program counter width
`define FETCH_LINE_BYTES  32        // bytes per instruction cache line
`define FETCH_LINE_INSTRS 8         // 32-bit instructions per line
`define FETCH_Q_DEPTH     16        // instruction queue entries, power of two
`define FETCH_RAS_DEPTH   8         // return stack entries, power of two
`define FETCH_RESET_PC    32'h0     // first fetch address out of reset

`endif

/* fetch_isa_pkg.sv */
// RV32I encodings seen by the fetch predecoder
// major opcodes that redirect fetch and the branch kinds derived from them
`default_nettype none

package fetch_isa_pkg;

   localparam int INSTR_W = 32;     // base instruction width
   localparam int OPC_W   = 5;      // major opcode, instr[6:2]
   localparam int REG_W   = 5;      // register specifier

   // full encodings of the system instructions that redirect fetch
   localparam logic [INSTR_W-1:0] MRET_INSTR   = 32'h3020_0073;
   localparam logic [INSTR_W-1:0] ECALL_INSTR  = 32'h0000_0073;
   localparam logic [INSTR_W-1:0] EBREAK_INSTR = 32'h0010_0073;

   typedef enum logic [OPC_W-1:0] {
      OP_BRANCH = 5'b11000,         // beq/bne/blt/bge/bltu/bgeu
      OP_JALR   = 5'b11001,
      OP_JAL    = 5'b11011,
      OP_SYSTEM = 5'b11100          // mret, ecall, ebreak, csr ops
   } opcode_e;

   typedef enum logic [2:0] {
      BK_PLAIN = 3'd0,              // falls through to pc+4
      BK_JALR  = 3'd1,
      BK_COND  = 3'd2,
      BK_JAL   = 3'd3,
      BK_MRET  = 3'd4,
      BK_TRAP  = 3'd5               // ecall / ebreak
   } branch_kind_e;

endpackage

`default_nettype wire

/* fetch_stimulus.txt */
# L line_addr w0 .. w7 gives one cache line with w0 at the lowest address
# E pc instruction predicted_addr gives the next expected entry at the decode port
# R after addr reloads the pc to addr once that many entries have been checked
L 00000000 00100113 00200193 00300213 00400313 00500393 00600413 00000863 00700493
L 00000020 00800513 040000ef 10000067 00000013 00000013 00000013 00000013 00000013
L 00000040 30200073 00000013 00000013 00000013 00000013 00000013 00000013 00000013
L 00000060 00000013 00a00613 fc000ce3 00000013 00000013 00000013 00000013 00000013
L 00000100 01100693 01200693 01300693 01400693 01500693 01600693 01700693 01800693
L 00000200 02100713 02200713 02300713 02400713 02500713 02600713 02700713 02800713
E 00000000 00100113 00000004
E 00000004 00200193 00000008
E 00000008 00300213 0000000c
E 0000000c 00400313 00000010
E 00000010 00500393 00000014
E 00000014 00600413 00000018
E 00000018 00000863 0000001c
E 0000001c 00700493 00000020
E 00000020 00800513 00000024
E 00000024 040000ef 00000064
E 00000064 00a00613 00000068
E 00000068 fc000ce3 00000040
E 00000040 30200073 00000028
E 00000028 10000067 00000100
E 00000100 01100693 00000104
E 00000104 01200693 00000108
E 00000108 01300693 0000010c
E 0000010c 01400693 00000110
E 00000110 01500693 00000114
E 00000114 01600693 00000118
E 00000118 01700693 0000011c
E 0000011c 01800693 00000120
R 22 00000208
E 00000208 02300713 0000020c
E 0000020c 02400713 00000210
E 00000210 02500713 00000214
E 00000214 02600713 00000218

/* fetch_top.sv */
// Instruction fetch unit
// requests cache lines, predecodes them, predicts the next fetch address
// with a return stack and queues instructions for decode
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_top
   import fetch_bus_pkg::*;
(
   input  logic                   clk_in,
   input  logic                   reset_in,
   input  logic                   pc_reload,
   input  logic [`FETCH_PC_W-1:0] pc_reload_addr,
   input  logic                   ic_ack,
   input  line_t                  ic_line,
   input  logic                   out_ready,
   output logic                   ic_req,
   output logic [`FETCH_PC_W-1:0] ic_addr,       // line address is the fetch pc
   output logic                   out_valid,
   output queue_entry_t           out_entry
);

   logic                                  take_line;
   logic                                  queue_full;
   logic [`FETCH_PC_W-1:0]                next_addr;
   logic [`FETCH_PC_W-1:0]                ras_top;
   ras_op_t                               ras_op;
   queue_entry_t [`FETCH_LINE_INSTRS-1:0] wr_entries;
   count_t                                wr_count;
   count_t                                free_slots;

   line_request i_line_request (
      .clk_in      (clk_in),
      .reset_in    (reset_in),
      .pc_reload   (pc_reload),
      .reload_addr (pc_reload_addr),
      .ic_ack      (ic_ack),
      .queue_full  (queue_full),
      .next_addr   (next_addr),
      .ic_req      (ic_req),
      .pc          (ic_addr),
      .take_line   (take_line)
   );

   line_predecode i_line_predecode (
      .take_line   (take_line),
      .pc          (ic_addr),
      .line        (ic_line),
      .free_slots  (free_slots),
      .ras_top     (ras_top),
      .wr_entries  (wr_entries),
      .wr_count    (wr_count),
      .next_addr   (next_addr),
      .ras_op      (ras_op)
   );

   return_stack i_return_stack (
      .clk_in      (clk_in),
      .reset_in    (reset_in),
      .ras_op      (ras_op),
      .ras_top     (ras_top)
   );

   instr_queue #(
      .DEPTH       (`FETCH_Q_DEPTH)
   ) i_instr_queue (
      .clk_in      (clk_in),
      .reset_in    (reset_in),
      .flush       (pc_reload),                  // wrong path entries dropped
      .wr_entries  (wr_entries),
      .wr_count    (wr_count),
      .out_ready   (out_ready),
      .out_valid   (out_valid),
      .out_entry   (out_entry),
      .free_slots  (free_slots),
      .full        (queue_full)
   );

endmodule

`default_nettype wire

/* instr_queue.sv */
// Instruction queue between fetch and decode
// circular buffer taking up to a line of entries per cycle and handing one
// entry per cycle to decode over valid/ready, cleared by flush
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module instr_queue
   import fetch_bus_pkg::*;
#(
   parameter int DEPTH = `FETCH_Q_DEPTH          // power of two so pointers wrap
)
(
   input  logic                                  clk_in,
   input  logic                                  reset_in,
   input  logic                                  flush,
   input  queue_entry_t [`FETCH_LINE_INSTRS-1:0] wr_entries,
   input  count_t                                wr_count,
   input  logic                                  out_ready,
   output logic                                  out_valid,
   output queue_entry_t                          out_entry,
   output count_t                                free_slots,
   output logic                                  full
);

   localparam int PTR_W = $clog2(DEPTH);

   queue_entry_t     mem [DEPTH];
   logic [PTR_W-1:0] ip;                         // write pointer
   logic [PTR_W-1:0] op;                         // read pointer
   count_t           count;
   logic             rd_en;

   assign out_valid  = (count != '0);
   assign out_entry  = mem[op];                  // head stays put until taken
   assign rd_en      = out_valid & out_ready;
   assign free_slots = count_t'(DEPTH) - count;
   assign full       = (count == count_t'(DEPTH));

   // -------------------------------------------------------------------------
   // pointers and fill count
   // -------------------------------------------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (reset_in || flush)                     // flush beats a same-cycle write
      begin
         ip    <= '0;
         op    <= '0;
         count <= '0;
      end
      else
      begin
         ip    <= ip + PTR_W'(wr_count);
         op    <= op + PTR_W'(rd_en);
         count <= count + wr_count - count_t'(rd_en);
      end
   end

   // entries land in consecutive slots from ip
   always_ff @(posedge clk_in)
   begin
      for (int i = 0; i < `FETCH_LINE_INSTRS; i++)
      begin
         if (count_t'(i) < wr_count)
            mem[ip + PTR_W'(i)] <= wr_entries[i];
      end
   end

   // walk must respect free_slots or unread entries get overwritten
   a_no_overfill: assert property (@(posedge clk_in) disable iff (reset_in)
      count <= count_t'(DEPTH))
      else $error("instruction queue count above depth");

endmodule

`default_nettype wire

/* line_predecode.sv */
// Cache line predecode walk
// starts at the pc's word in the returned line, predecodes each 32-bit word,
// predicts the next fetch address and stops at the first taken branch, the
// end of the line, a full queue or a non-32-bit encoding
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module line_predecode
   import fetch_isa_pkg::*, fetch_bus_pkg::*;
(
   input  logic                                         take_line,
   input  logic [`FETCH_PC_W-1:0]                       pc,
   input  line_t                                        line,
   input  count_t                                       free_slots,
   input  logic [`FETCH_PC_W-1:0]                       ras_top,
   output queue_entry_t [`FETCH_LINE_INSTRS-1:0]        wr_entries,
   output count_t                                       wr_count,
   output logic [`FETCH_PC_W-1:0]                       next_addr,
   output ras_op_t                                      ras_op
);

   localparam int PC_W  = `FETCH_PC_W;
   localparam int OFS_W = $clog2(`FETCH_LINE_BYTES);     // byte offset bits in a line

   slot_t             slot;
   logic [PC_W-1:0]   cur_pc;                            // pc of the word being walked
   logic [PC_W-1:0]   seq_pc;
   logic [PC_W-1:0]   pred;
   logic              taken;
   logic              done;

   function automatic logic is_link(input logic [REG_W-1:0] r);
      return (r == REG_W'(1)) || (r == REG_W'(5));       // x1 / x5 link registers
   endfunction

   function automatic slot_t predecode(input logic [INSTR_W-1:0] i);
      slot_t s;
      s.instr = i;
      s.is32  = (i[1:0] == 2'b11) && (i[4:2] != 3'b111);
      s.i_imm = {{20{i[31]}}, i[31:20]};
      s.b_imm = {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
      s.j_imm = {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
      s.rd    = i[11:7];
      s.rs1   = i[19:15];
      s.kind  = BK_PLAIN;
      if (s.is32)
      begin
         case (opcode_e'(i[6:2]))
            OP_BRANCH: s.kind = BK_COND;
            OP_JALR:
            begin
               if (i[14:12] == 3'b000)
                  s.kind = BK_JALR;
            end
            OP_JAL:    s.kind = BK_JAL;
            OP_SYSTEM:
            begin
               if (i == MRET_INSTR)
                  s.kind = BK_MRET;
               else if (i == ECALL_INSTR || i == EBREAK_INSTR)
                  s.kind = BK_TRAP;
            end
            default:   s.kind = BK_PLAIN;
         endcase
      end
      return s;
   endfunction

   // -------------------------------------------------------------------------
   // line walk
   // -------------------------------------------------------------------------
   always_comb
   begin
      wr_entries = '0;
      wr_count   = '0;
      ras_op     = '0;
      next_addr  = pc;                                   // nothing stored, refetch pc
      cur_pc     = pc;
      slot       = '0;
      seq_pc     = pc;
      pred       = pc;
      taken      = 1'b0;
      done       = !take_line || (free_slots == '0);

      for (int c = 0; c < `FETCH_LINE_INSTRS; c++)
      begin
         if (!done)
         begin
            slot   = predecode(line[{cur_pc[OFS_W-1:2], 5'd0} +: INSTR_W]);
            seq_pc = cur_pc + PC_W'(4);
            pred   = seq_pc;
            taken  = 1'b0;

            case (slot.kind)
               BK_JALR:
               begin
                  pred             = slot.i_imm;         // guess rs1 = x0
                  taken            = 1'b1;
                  ras_op.push      = is_link(slot.rd);
                  ras_op.pop       = is_link(slot.rs1) &&
                                     !(is_link(slot.rd) && slot.rs1 == slot.rd);
                  ras_op.push_addr = seq_pc;
               end
               BK_COND:
               begin
                  taken = slot.b_imm[PC_W-1];            // backward taken, forward not
                  if (taken)
                     pred = cur_pc + slot.b_imm;
               end
               BK_JAL:
               begin
                  pred             = cur_pc + slot.j_imm;
                  taken            = 1'b1;
                  ras_op.push      = is_link(slot.rd);   // call only through x1/x5
                  ras_op.push_addr = seq_pc;
               end
               BK_MRET:
               begin
                  pred       = ras_top;
                  taken      = 1'b1;
                  ras_op.pop = 1'b1;
               end
               BK_TRAP:
               begin
                  pred  = '0;                            // trap vector at zero
                  taken = 1'b1;
               end
               default: pred = seq_pc;
            endcase

            wr_entries[c] = '{instruction: slot.instr, pc: cur_pc, predicted_addr: pred};
            wr_count      = wr_count + 1'b1;
            next_addr     = pred;
            cur_pc        = seq_pc;

            // taken branches end the walk, so only the last word reaches the stack
            done = taken || !slot.is32 || (cur_pc[OFS_W-1:2] == '0) ||
                   (wr_count == free_slots);
         end
      end
   end

endmodule

`default_nettype wire

/* line_request.sv */
// Cache line request control
// holds the fetch pc, raises ic_req while the queue has room and tracks
// pc reloads so a line fetched before a reload is thrown away
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module line_request
(
   input  logic                   clk_in,
   input  logic                   reset_in,
   input  logic                   pc_reload,
   input  logic [`FETCH_PC_W-1:0] reload_addr,
   input  logic                   ic_ack,
   input  logic                   queue_full,
   input  logic [`FETCH_PC_W-1:0] next_addr,     // predicted address after the walk
   output logic                   ic_req,
   output logic [`FETCH_PC_W-1:0] pc,
   output logic                   take_line      // transfer worth walking
);

   typedef enum logic [1:0] {
      IDLE,
      WAIT_ACK,
      WAIT_RELOAD_ACK
   } state_e;

   state_e                   state;
   logic                     xfer;               // req and ack both high
   logic                     reload_flag;        // reload seen, not yet fetched
   logic                     reload_match;       // pending reload is the one in flight
   logic [`FETCH_PC_W-1:0]   reload_pc;
   logic [`FETCH_PC_W-1:0]   lpa;                // last predicted address

   assign xfer         = ic_req & ic_ack;
   assign reload_match = (pc == reload_pc);

   // a line requested before the last reload carries the wrong path
   always_comb
   begin
      case (state)
         WAIT_ACK:        take_line = xfer & ~reload_flag;
         WAIT_RELOAD_ACK: take_line = xfer & reload_match;
         default:         take_line = 1'b0;
      endcase
   end

   // -------------------------------------------------------------------------
   // request FSM
   // -------------------------------------------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (reset_in)
      begin
         state       <= IDLE;
         ic_req      <= 1'b0;
         pc          <= `FETCH_RESET_PC;
         lpa         <= `FETCH_RESET_PC;
         reload_flag <= 1'b0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               if (!queue_full)
               begin
                  ic_req <= 1'b1;
                  pc     <= reload_flag ? reload_pc : lpa;
                  state  <= reload_flag ? WAIT_RELOAD_ACK : WAIT_ACK;
               end
            end
            WAIT_ACK, WAIT_RELOAD_ACK:
            begin
               if (xfer)
               begin
                  ic_req <= 1'b0;                // drop req the cycle after transfer
                  state  <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase

         if (take_line)
            lpa <= next_addr;                    // resume after last stored entry

         // a newer reload keeps the flag up even if an older one lands now
         if (pc_reload)
            reload_flag <= 1'b1;
         else if (state == WAIT_RELOAD_ACK && xfer && reload_match)
            reload_flag <= 1'b0;
      end

      if (pc_reload)
         reload_pc <= reload_addr;
   end

   // once raised, req waits for the cache to take it
   a_req_held: assert property (@(posedge clk_in) disable iff (reset_in)
      ic_req && !ic_ack |=> ic_req)
      else $error("ic_req dropped without a transfer");

endmodule

`default_nettype wire

/* project.f */
+incdir+.
fetch_isa_pkg.sv
fetch_bus_pkg.sv
line_request.sv
line_predecode.sv
return_stack.sv
instr_queue.sv
fetch_top.sv
tb_fetch.sv

/* return_stack.sv */
// Return address stack
// circular stack of predicted return addresses, pointer wraps on over and
// underflow, a pop-then-push pops first
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module return_stack
   import fetch_bus_pkg::*;
(
   input  logic                   clk_in,
   input  logic                   reset_in,
   input  ras_op_t                ras_op,
   output logic [`FETCH_PC_W-1:0] ras_top
);

   localparam int DEPTH = `FETCH_RAS_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);

   logic [`FETCH_PC_W-1:0] mem [DEPTH];
   logic [PTR_W-1:0]       ptr;                  // next free entry
   logic [PTR_W-1:0]       ptr_pop;              // pointer after the pop half
   logic [PTR_W-1:0]       top_idx;

   assign ptr_pop = ras_op.pop ? ptr - 1'b1 : ptr;
   assign top_idx = ptr - 1'b1;                  // entry below the pointer
   assign ras_top = mem[top_idx];

   always_ff @(posedge clk_in)
   begin
      if (reset_in)
         ptr <= '0;
      else
         ptr <= ptr_pop + PTR_W'(ras_op.push);
   end

   // push overwrites the slot a same-cycle pop just freed
   always_ff @(posedge clk_in)
   begin
      if (ras_op.push)
         mem[ptr_pop] <= ras_op.push_addr;
   end

endmodule

`default_nettype wire

/* tb_fetch.sv */
// Testbench for the instruction fetch unit
// a cache model serves lines from the stimulus file, the decode side takes
// entries with random stalls and checks them against the expected list,
// reload records stall decode, then redirect fetch with pc_reload
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module tb_fetch
   import fetch_bus_pkg::*;
();

   localparam int ENTRY_TIMEOUT = 200;                   // cycles allowed between entries
   localparam int RELOAD_STALL  = 20;

   logic                   clk_in;
   logic                   reset_in;
   logic                   pc_reload;
   logic [`FETCH_PC_W-1:0] pc_reload_addr;
   logic                   ic_ack = 1'b0;
   line_t                  ic_line = '0;
   logic                   out_ready;
   logic                   ic_req;
   logic [`FETCH_PC_W-1:0] ic_addr;
   logic                   out_valid;
   queue_entry_t           out_entry;

   logic [`FETCH_PC_W-1:0] line_addr_q [$];              // cache contents
   line_t                  line_data_q [$];
   queue_entry_t           exp_q [$];                    // expected decode stream
   int                     reload_after_q [$];
   logic [`FETCH_PC_W-1:0] reload_addr_q [$];
   int                     ack_delay = -1;               // -1 while no request pending

   fetch_top i_fetch_top (
      .clk_in         (clk_in),
      .reset_in       (reset_in),
      .pc_reload      (pc_reload),
      .pc_reload_addr (pc_reload_addr),
      .ic_ack         (ic_ack),
      .ic_line        (ic_line),
      .out_ready      (out_ready),
      .ic_req         (ic_req),
      .ic_addr        (ic_addr),
      .out_valid      (out_valid),
      .out_entry      (out_entry)
   );

   initial
   begin
      clk_in = 1'b0;
      forever #5 clk_in = ~clk_in;
   end

   // -------------------------------------------------------------------------
   // cache model
   // -------------------------------------------------------------------------
   // addi x0, x0, imm with imm folded from the whole address
   function automatic logic [31:0] fill_word(input logic [31:0] addr);
      return {addr[31:20] ^ addr[19:8] ^ addr[11:0], 13'd0, 7'h13};
   endfunction

   function automatic line_t line_lookup(input logic [`FETCH_PC_W-1:0] addr);
      logic [`FETCH_PC_W-1:0] base;
      line_t                  l;
      base = {addr[`FETCH_PC_W-1:5], 5'd0};             // line aligned
      for (int k = 0; k < `FETCH_LINE_INSTRS; k++)
         l[32*k +: 32] = fill_word(base + 32'(4*k));
      foreach (line_addr_q[j])
      begin
         if (line_addr_q[j] == base)
            l = line_data_q[j];
      end
      return l;
   endfunction

   task automatic serve_cache();
      if (reset_in || (ic_req && ic_ack))
      begin
         ic_ack    <= 1'b0;                              // transfer seen and req drops too
         ack_delay = -1;
      end
      else if (ic_req)
      begin
         if (ack_delay < 0)
            ack_delay = $urandom % 4;                    // 0..3 extra cycles
         if (ack_delay == 0)
         begin
            ic_ack  <= 1'b1;
            ic_line <= line_lookup(ic_addr);
         end
         else
            ack_delay = ack_delay - 1;
      end
   endtask

   task automatic next_cycle();
      @(posedge clk_in);
      serve_cache();
   endtask

   // -------------------------------------------------------------------------
   // stimulus file and checks
   // -------------------------------------------------------------------------
   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("test failed");
      $fatal(1, "run stopped");
   endtask

   task automatic read_stimulus();
      int                     fd;
      int                     n;
      int                     cnt;
      string                  txt;
      logic [31:0]            a;
      logic [31:0]            b;
      logic [31:0]            c;
      logic [31:0]            w [8];
      line_t                  l;
      queue_entry_t           e;
      fd = $fopen("fetch_stimulus.txt", "r");
      if (fd == 0)
         stop_on_error("cannot open fetch_stimulus.txt");
      while (!$feof(fd))
      begin
         txt = "";
         n   = $fgets(txt, fd);
         if (n > 1 && txt.substr(0, 0) == "L")
         begin
            n = $sscanf(txt, "L %h %h %h %h %h %h %h %h %h", a,
                        w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
            for (int k = 0; k < 8; k++)
               l[32*k +: 32] = w[k];                     // word 0 at the lowest address
            line_addr_q.push_back(a);
            line_data_q.push_back(l);
         end
         else if (n > 1 && txt.substr(0, 0) == "E")
         begin
            n                = $sscanf(txt, "E %h %h %h", a, b, c);
            e.pc             = a;
            e.instruction    = b;
            e.predicted_addr = c;
            exp_q.push_back(e);
         end
         else if (n > 1 && txt.substr(0, 0) == "R")
         begin
            n = $sscanf(txt, "R %d %h", cnt, a);
            reload_after_q.push_back(cnt);
            reload_addr_q.push_back(a);
         end
      end
      $fclose(fd);
      if (exp_q.size() == 0)
         stop_on_error("stimulus file holds no expected entries");
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("Fail at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
         $display("test failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // hold decode off until the queue is full, then redirect
   task automatic issue_reload(input logic [`FETCH_PC_W-1:0] addr);
      out_ready <= 1'b0;
      repeat (RELOAD_STALL) next_cycle();
      pc_reload      <= 1'b1;
      pc_reload_addr <= addr;
      next_cycle();
      pc_reload      <= 1'b0;
   endtask

   initial
   begin
      int           idx;
      int           ri;
      int           idle_cycles;
      logic         got_entry;
      queue_entry_t e;
      void'($urandom(32'h2d9d6fc1));
      reset_in       = 1'b1;
      pc_reload      = 1'b0;
      pc_reload_addr = '0;
      out_ready      = 1'b0;
      read_stimulus();
      repeat (10) next_cycle();
      reset_in <= 1'b0;

      // first cycle out of reset is quiet, the request follows one cycle later
      next_cycle();
      check_value("ic_req after reset", 32'(ic_req), 32'd0);
      check_value("out_valid after reset", 32'(out_valid), 32'd0);
      next_cycle();
      check_value("ic_req on first request", 32'(ic_req), 32'd1);
      check_value("ic_addr on first request", ic_addr, `FETCH_RESET_PC);

      idx = 0;
      ri  = 0;
      while (idx < exp_q.size())
      begin
         idle_cycles = 0;
         got_entry   = 1'b0;
         while (!got_entry)                              // next decode handshake
         begin
            next_cycle();
            got_entry = out_valid && out_ready;
            if (!got_entry)
            begin
               idle_cycles++;
               if (idle_cycles > ENTRY_TIMEOUT)
                  stop_on_error($sformatf("no entry %0d from the fetch unit in %0d cycles",
                                          idx, ENTRY_TIMEOUT));
               out_ready <= (($urandom % 4) == 0);      // mostly stalled so the queue fills
            end
         end
         e = exp_q[idx];
         check_value($sformatf("entry %0d pc", idx), out_entry.pc, e.pc);
         check_value($sformatf("entry %0d instruction", idx), out_entry.instruction,
                     e.instruction);
         check_value($sformatf("entry %0d predicted_addr", idx), out_entry.predicted_addr,
                     e.predicted_addr);
         idx++;
         if (ri < reload_after_q.size() && reload_after_q[ri] == idx)
         begin
            issue_reload(reload_addr_q[ri]);
            ri++;
         end
         else
            out_ready <= (($urandom % 4) == 0);
      end
      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire
